// File: exe_pkg.sv
// Execute stage shared definitions
`default_nettype none

package exe_pkg;

  // Datapath widths fixed by RV32
  localparam int DATA_WIDTH         = 32;
  localparam int REG_ADDR_WIDTH     = 5;
  localparam int ALU_OP_WIDTH       = 5;   // Bit 4 flags the M extension
  localparam int MEM_TRANSFER_WIDTH = 4;   // One byte enable per byte lane
  localparam int LOAD_OP_WIDTH      = 3;
  localparam int DATA_ORIGIN_WIDTH  = 2;

  // Iterative multiply/divide
  localparam int MD_STEPS     = 32;              // One bit per step
  localparam int MD_CNT_WIDTH = $clog2(MD_STEPS);

  // RV32I operations, carried in alu_op[3:0]
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10   // lui
  } alu_op_e;

  // RV32M operations, equal to funct3 in alu_op[2:0]
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_op_e;

  typedef enum logic [1:0] {
    ST_SB   = 2'd0,
    ST_SH   = 2'd1,
    ST_SW   = 2'd2,
    ST_NONE = 2'd3
  } store_op_e;

  // Write-back source
  typedef enum logic [1:0] {
    TGT_ALU        = 2'd0,
    TGT_STORE_DATA = 2'd1,
    TGT_ZERO       = 2'd2,
    TGT_LINK       = 2'd3   // pc+4 or branch target
  } target_e;

  // Decoded instruction as presented by decode
  typedef struct packed {
    logic [ALU_OP_WIDTH-1:0]       alu_op;
    store_op_e                     store_op;
    logic [LOAD_OP_WIDTH-1:0]      load_op;
    logic [DATA_ORIGIN_WIDTH-1:0]  data_origin;  // [0] imm as op2, [1] pc4 as link
    logic [DATA_WIDTH-1:0]         rs1;
    logic [DATA_WIDTH-1:0]         rs2;
    logic [DATA_WIDTH-1:0]         imm;
    logic [DATA_WIDTH-1:0]         pc4;
    logic [DATA_WIDTH-1:0]         brj_pc;
    logic [REG_ADDR_WIDTH-1:0]     waddr;
    logic                          reg_wr;
    logic                          data_rd;
    logic                          data_wr;
    logic                          is_load_store;
    logic [MEM_TRANSFER_WIDTH-1:0] be;
    target_e                       data_target;
  } exe_in_t;

  // Request towards the memory stage
  typedef struct packed {
    logic [DATA_WIDTH-1:0]         data_addr;
    logic                          data_rd;
    logic                          data_wr;
    logic [MEM_TRANSFER_WIDTH-1:0] be;
    logic                          is_load_store;
    logic [LOAD_OP_WIDTH-1:0]      load_op;
  } mem_req_t;

  typedef struct packed {
    logic [REG_ADDR_WIDTH-1:0] waddr;
    logic                      reg_wr;
    logic [DATA_WIDTH-1:0]     rd_value;
  } wb_t;

endpackage

`default_nettype wire

// File: alu.sv
// RV32I arithmetic logic unit
`default_nettype none

module alu (
  input  logic [exe_pkg::DATA_WIDTH-1:0] a_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] b_i,
  input  exe_pkg::alu_op_e               op_i,
  output logic [exe_pkg::DATA_WIDTH-1:0] result_o
);

  import exe_pkg::*;

  logic [4:0]            shamt;     // Only the low five bits shift
  logic [DATA_WIDTH-1:0] sum;
  logic [DATA_WIDTH-1:0] diff;
  logic                  lt_signed;
  logic                  lt_unsigned;

  assign shamt       = b_i[4:0];
  assign sum         = a_i + b_i;
  assign diff        = a_i - b_i;
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = sum;
      ALU_SUB:    result_o = diff;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(DATA_WIDTH-1){1'b0}}, lt_signed};   // 0 or 1
      ALU_SLTU:   result_o = {{(DATA_WIDTH-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt);      // Sign fill
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;                                   // lui immediate
      default:    result_o = '0;                                    // Unused codes
    endcase
  end

endmodule

`default_nettype wire

// File: muldiv.sv
// Iterative RV32M multiply and divide
`default_nettype none

module muldiv (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start_i,
  input  exe_pkg::md_op_e                op_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] a_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] b_i,
  output logic                           done_o,
  output logic [exe_pkg::DATA_WIDTH-1:0] result_o
);

  import exe_pkg::*;

  // Control state
  logic                    running;
  logic [MD_CNT_WIDTH-1:0] cnt;
  logic                    done_q;

  // Working registers, {hi, lo} shared by both algorithms
  logic [2*DATA_WIDTH-1:0] acc;
  logic [DATA_WIDTH-1:0]   b_mag;      // Multiplicand or divisor magnitude
  md_op_e                  op_q;
  logic                    neg_q;      // Result needs negation

  // Operand conditioning at start
  logic                    a_signed;
  logic                    b_signed;
  logic                    a_neg;
  logic                    b_neg;
  logic [DATA_WIDTH-1:0]   a_mag_d;
  logic [DATA_WIDTH-1:0]   b_mag_d;
  logic                    neg_d;

  // One iteration
  logic [DATA_WIDTH:0]     mul_sum;
  logic [DATA_WIDTH:0]     rem_sh;
  logic [DATA_WIDTH:0]     div_diff;
  logic                    last_step;

  // Sign correction on the way out
  logic [2*DATA_WIDTH-1:0] prod;
  logic [DATA_WIDTH-1:0]   quo;
  logic [DATA_WIDTH-1:0]   rem;

  always_comb begin
    a_signed = (op_i == MD_MULH) || (op_i == MD_MULHSU) || (op_i == MD_DIV) ||
               (op_i == MD_REM);
    b_signed = (op_i == MD_MULH) || (op_i == MD_DIV) || (op_i == MD_REM);
    a_neg    = a_signed && a_i[DATA_WIDTH-1];
    b_neg    = b_signed && b_i[DATA_WIDTH-1];
    a_mag_d  = a_neg ? -a_i : a_i;
    b_mag_d  = b_neg ? -b_i : b_i;
    if (!op_i[2]) begin
      neg_d = a_neg ^ b_neg;                 // Product sign
    end else if (op_i[1]) begin
      neg_d = a_neg;                         // Remainder follows dividend
    end else begin
      neg_d = (a_neg ^ b_neg) && (|b_i);     // Divide by zero keeps all ones
    end
  end

  assign mul_sum   = {1'b0, acc[2*DATA_WIDTH-1:DATA_WIDTH]} + (acc[0] ? {1'b0, b_mag} : '0);
  assign rem_sh    = acc[2*DATA_WIDTH-1:DATA_WIDTH-1];   // Partial remainder shifted left
  assign div_diff  = rem_sh - {1'b0, b_mag};            // MSB set means borrow
  assign last_step = cnt == MD_CNT_WIDTH'(MD_STEPS - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running <= 1'b0;
      cnt     <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= running && last_step;        // Pulse the cycle after the final step
      if (start_i) begin
        running <= 1'b1;
        cnt     <= '0;
      end else if (running) begin
        cnt <= cnt + 1'b1;
        if (last_step) begin
          running <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc   <= {{DATA_WIDTH{1'b0}}, a_mag_d};
      b_mag <= b_mag_d;
      op_q  <= op_i;
      neg_q <= neg_d;
    end else if (running) begin
      if (!op_q[2]) begin
        acc <= {mul_sum, acc[DATA_WIDTH-1:1]};                       // Shift-add
      end else if (!div_diff[DATA_WIDTH]) begin
        acc <= {div_diff[DATA_WIDTH-1:0], acc[DATA_WIDTH-2:0], 1'b1}; // Subtract fits
      end else begin
        acc <= {acc[2*DATA_WIDTH-2:0], 1'b0};                         // Restore
      end
    end
  end

  always_comb begin
    prod = neg_q ? -acc : acc;
    quo  = neg_q ? -acc[DATA_WIDTH-1:0] : acc[DATA_WIDTH-1:0];
    rem  = neg_q ? -acc[2*DATA_WIDTH-1:DATA_WIDTH] : acc[2*DATA_WIDTH-1:DATA_WIDTH];
    case (op_q)
      MD_MUL:                        result_o = prod[DATA_WIDTH-1:0];
      MD_MULH, MD_MULHSU, MD_MULHU:  result_o = prod[2*DATA_WIDTH-1:DATA_WIDTH];
      MD_DIV, MD_DIVU:               result_o = quo;
      default:                       result_o = rem;
    endcase
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// File: exe_ctrl.sv
// Multi-cycle start and stage enable control
`default_nettype none

module exe_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic m_req_i,          // Current instruction is an M operation
  input  logic stall_general_i,
  input  logic md_done_i,
  output logic md_start_o,
  output logic busy_o,
  output logic stage_en_o
);

  typedef enum logic [1:0] {
    CS_IDLE = 2'd0,
    CS_RUN  = 2'd1,
    CS_FIN  = 2'd2   // Result ready, stage not yet advanced
  } ctrl_state_e;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        finished;

  always_comb begin
    finished   = (state_q == CS_FIN) || ((state_q == CS_RUN) && md_done_i);
    md_start_o = m_req_i && (state_q == CS_IDLE);               // Never while finished
    busy_o     = md_start_o || ((state_q == CS_RUN) && !md_done_i);
    stage_en_o = !stall_general_i && (!m_req_i || finished);

    state_d = state_q;
    case (state_q)
      CS_IDLE: begin
        if (md_start_o) begin
          state_d = CS_RUN;
        end
      end
      CS_RUN: begin
        if (md_done_i) begin
          state_d = stage_en_o ? CS_IDLE : CS_FIN;   // Held by stall keeps the result
        end
      end
      CS_FIN: begin
        if (stage_en_o) begin
          state_d = CS_IDLE;                         // Cleared on the enabled edge
        end
      end
      default: state_d = CS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= CS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

// File: wb_select.sv
// Store data and write-back value selection
`default_nettype none

module wb_select (
  input  exe_pkg::target_e               target_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] result_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] rs2_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] pc4_i,
  input  logic [exe_pkg::DATA_WIDTH-1:0] brj_pc_i,
  input  logic                           link_pc4_i,   // data_origin[1]
  input  exe_pkg::store_op_e             store_op_i,
  output logic [exe_pkg::DATA_WIDTH-1:0] store_data_o,
  output logic [exe_pkg::DATA_WIDTH-1:0] rd_value_o
);

  import exe_pkg::*;

  logic [DATA_WIDTH-1:0] link_addr;

  assign link_addr = link_pc4_i ? pc4_i : brj_pc_i;   // jal/jalr link or branch target

  // Store formatting, zero extended into the low lanes
  always_comb begin
    case (store_op_i)
      ST_SB:   store_data_o = {{(DATA_WIDTH-8){1'b0}}, rs2_i[7:0]};
      ST_SH:   store_data_o = {{(DATA_WIDTH-16){1'b0}}, rs2_i[15:0]};
      ST_SW:   store_data_o = rs2_i;
      default: store_data_o = '0;   // Not a store
    endcase
  end

  always_comb begin
    case (target_i)
      TGT_ALU:        rd_value_o = result_i;
      TGT_STORE_DATA: rd_value_o = store_data_o;
      TGT_ZERO:       rd_value_o = '0;
      default:        rd_value_o = link_addr;
    endcase
  end

endmodule

`default_nettype wire

// File: stage_reg.sv
// Enabled pipeline register
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en_i,     // Low holds the stage
  input  payload_t d_i,
  output payload_t q_o
);

  // All fields clear so valid strobes are inactive after reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q_o <= '0;
    end else if (en_i) begin
      q_o <= d_i;
    end
  end

endmodule

`default_nettype wire

// File: exe_stage.sv
// RV32IM execute stage
`default_nettype none

module exe_stage (
  input  logic                           clk,
  input  logic                           rst_n,
  input  exe_pkg::exe_in_t               e_in_i,
  input  logic                           stall_general_i,
  output exe_pkg::mem_req_t              m_req_o,
  output exe_pkg::wb_t                   m_wb_o,
  output logic                           alu_busy_o,
  output logic [exe_pkg::DATA_WIDTH-1:0] alu_o      // Unregistered, for forwarding
);

  import exe_pkg::*;

  logic [DATA_WIDTH-1:0] op1;
  logic [DATA_WIDTH-1:0] op2;
  logic [DATA_WIDTH-1:0] alu_res;
  logic [DATA_WIDTH-1:0] md_res;
  logic [DATA_WIDTH-1:0] result;
  logic [DATA_WIDTH-1:0] rd_value;
  logic                  m_req;
  logic                  md_start;
  logic                  md_done;
  logic                  stage_en;
  mem_req_t              mem_d;
  wb_t                   wb_d;

  // Operand selection
  assign op1   = e_in_i.rs1;
  assign op2   = e_in_i.data_origin[0] ? e_in_i.imm : e_in_i.rs2;
  assign m_req = e_in_i.alu_op[4];

  alu u_alu (
    .a_i      (op1),
    .b_i      (op2),
    .op_i     (alu_op_e'(e_in_i.alu_op[3:0])),
    .result_o (alu_res)
  );

  muldiv u_muldiv (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (md_start),
    .op_i     (md_op_e'(e_in_i.alu_op[2:0])),   // funct3
    .a_i      (op1),
    .b_i      (op2),
    .done_o   (md_done),
    .result_o (md_res)
  );

  exe_ctrl u_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .m_req_i         (m_req),
    .stall_general_i (stall_general_i),
    .md_done_i       (md_done),
    .md_start_o      (md_start),
    .busy_o          (alu_busy_o),
    .stage_en_o      (stage_en)
  );

  assign result = m_req ? md_res : alu_res;
  assign alu_o  = result;

  // Store data reaches memory through rd_value with the STORE_DATA target
  wb_select u_wb_select (
    .target_i     (e_in_i.data_target),
    .result_i     (result),
    .rs2_i        (e_in_i.rs2),
    .pc4_i        (e_in_i.pc4),
    .brj_pc_i     (e_in_i.brj_pc),
    .link_pc4_i   (e_in_i.data_origin[1]),
    .store_op_i   (e_in_i.store_op),
    .store_data_o (),
    .rd_value_o   (rd_value)
  );

  always_comb begin
    mem_d.data_addr     = result;   // Base plus offset from the ALU
    mem_d.data_rd       = e_in_i.data_rd;
    mem_d.data_wr       = e_in_i.data_wr;
    mem_d.be            = e_in_i.be;
    mem_d.is_load_store = e_in_i.is_load_store;
    mem_d.load_op       = e_in_i.load_op;
    wb_d.waddr          = e_in_i.waddr;
    wb_d.reg_wr         = e_in_i.reg_wr;
    wb_d.rd_value       = rd_value;
  end

  stage_reg #(.payload_t(mem_req_t)) u_mem_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .en_i  (stage_en),
    .d_i   (mem_d),
    .q_o   (m_req_o)
  );

  stage_reg #(.payload_t(wb_t)) u_wb_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .en_i  (stage_en),
    .d_i   (wb_d),
    .q_o   (m_wb_o)
  );

endmodule

`default_nettype wire

// File: tb_exe_stage.sv
// Execute stage testbench
`default_nettype none

module tb_exe_stage;
  timeunit 1ns;
  timeprecision 100ps;

  import exe_pkg::*;

  logic                  clk;
  logic                  rst_n;
  exe_in_t               e_in;
  logic                  stall_general_i;
  mem_req_t              m_req;
  wb_t                   m_wb;
  logic                  alu_busy;
  logic [DATA_WIDTH-1:0] alu_out;

  integer   seed;
  int       checks;
  int       errors;
  int       timeouts;
  bit       abort;      // Set on a timeout to end the remaining loops
  mem_req_t exp_req;    // What the stage registers should hold now
  wb_t      exp_wb;

  exe_stage dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .e_in_i          (e_in),
    .stall_general_i (stall_general_i),
    .m_req_o         (m_req),
    .m_wb_o          (m_wb),
    .alu_busy_o      (alu_busy),
    .alu_o           (alu_out)
  );

  always #50 clk = ~clk;   // 100 ns period

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      $display("CHECK FAILED: %s got 0x%08h expected 0x%08h at %0t", name, got, want, $time);
      errors++;
    end
  endtask

  // Reference RV32I and RV32M semantics on ISA operands
  function automatic logic [31:0] model_result(input exe_in_t ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] sa;
    logic [63:0] sb;
    logic [63:0] ua;
    logic [63:0] ub;
    logic [63:0] p;
    logic [31:0] res;
    int          qa;
    int          qb;
    a  = ins.rs1;
    b  = ins.data_origin[0] ? ins.imm : ins.rs2;
    sa = {{32{a[31]}}, a};   // Sign extended for an exact 64-bit product
    sb = {{32{b[31]}}, b};
    ua = {32'd0, a};
    ub = {32'd0, b};
    qa = a;
    qb = b;
    p  = '0;
    if (ins.alu_op[4]) begin
      case (md_op_e'(ins.alu_op[2:0]))
        MD_MUL: begin
          p   = ua * ub;
          res = p[31:0];
        end
        MD_MULH: begin
          p   = sa * sb;
          res = p[63:32];
        end
        MD_MULHSU: begin
          p   = sa * ub;
          res = p[63:32];
        end
        MD_MULHU: begin
          p   = ua * ub;
          res = p[63:32];
        end
        MD_DIV: begin
          if (b == 32'd0) res = 32'hffff_ffff;                           // Divide by zero
          else if (a == 32'h8000_0000 && b == 32'hffff_ffff) res = a;    // Overflow
          else res = qa / qb;                                            // Truncates to zero
        end
        MD_DIVU:   res = (b == 32'd0) ? 32'hffff_ffff : a / b;
        MD_REM: begin
          if (b == 32'd0) res = a;
          else if (a == 32'h8000_0000 && b == 32'hffff_ffff) res = 32'd0;
          else res = qa % qb;    // Sign of the dividend
        end
        default:   res = (b == 32'd0) ? a : a % b;                       // REMU
      endcase
    end else begin
      case (alu_op_e'(ins.alu_op[3:0]))
        ALU_ADD:    res = a + b;
        ALU_SUB:    res = a - b;
        ALU_SLL:    res = a << b[4:0];
        ALU_SLT:    res = (qa < qb) ? 32'd1 : 32'd0;
        ALU_SLTU:   res = (a < b) ? 32'd1 : 32'd0;
        ALU_XOR:    res = a ^ b;
        ALU_SRL:    res = a >> b[4:0];
        ALU_SRA:    res = qa >>> b[4:0];
        ALU_OR:     res = a | b;
        ALU_AND:    res = a & b;
        ALU_PASS_B: res = b;
        default:    res = 32'd0;
      endcase
    end
    return res;
  endfunction

  // Expected stage register contents for one instruction
  task automatic predict(input exe_in_t ins, output mem_req_t r, output wb_t w);
    logic [31:0] res;
    logic [31:0] sdata;
    res = model_result(ins);
    case (ins.store_op)
      ST_SB:   sdata = ins.rs2 & 32'h0000_00ff;
      ST_SH:   sdata = ins.rs2 & 32'h0000_ffff;
      ST_SW:   sdata = ins.rs2;
      default: sdata = 32'd0;
    endcase
    r.data_addr     = res;
    r.data_rd       = ins.data_rd;
    r.data_wr       = ins.data_wr;
    r.be            = ins.be;
    r.is_load_store = ins.is_load_store;
    r.load_op       = ins.load_op;
    w.waddr         = ins.waddr;
    w.reg_wr        = ins.reg_wr;
    case (ins.data_target)
      TGT_ALU:        w.rd_value = res;
      TGT_STORE_DATA: w.rd_value = sdata;
      TGT_ZERO:       w.rd_value = 32'd0;
      default:        w.rd_value = ins.data_origin[1] ? ins.pc4 : ins.brj_pc;   // Link
    endcase
  endtask

  task automatic check_outputs(input mem_req_t r, input wb_t w);
    check_val("m_req_o.data_addr", m_req.data_addr, r.data_addr);
    check_val("m_req_o.data_rd", 32'(m_req.data_rd), 32'(r.data_rd));
    check_val("m_req_o.data_wr", 32'(m_req.data_wr), 32'(r.data_wr));
    check_val("m_req_o.be", 32'(m_req.be), 32'(r.be));
    check_val("m_req_o.is_load_store", 32'(m_req.is_load_store), 32'(r.is_load_store));
    check_val("m_req_o.load_op", 32'(m_req.load_op), 32'(r.load_op));
    check_val("m_wb_o.waddr", 32'(m_wb.waddr), 32'(w.waddr));
    check_val("m_wb_o.reg_wr", 32'(m_wb.reg_wr), 32'(w.reg_wr));
    check_val("m_wb_o.rd_value", m_wb.rd_value, w.rd_value);
  endtask

  task automatic rand_instr(input bit m_op, input bit alu_target, output exe_in_t ins);
    logic [31:0] r;
    r = $random(seed);
    ins.alu_op        = m_op ? {2'b10, r[2:0]} : {1'b0, r[7:4] % 4'd11};   // Bit 4 is M
    ins.store_op      = store_op_e'(r[9:8]);
    ins.load_op       = r[12:10];
    ins.data_origin   = r[14:13];
    ins.waddr         = r[19:15];
    ins.reg_wr        = r[20];
    ins.data_rd       = r[21];
    ins.data_wr       = r[22];
    ins.is_load_store = r[23];
    ins.be            = r[27:24];
    ins.data_target   = alu_target ? TGT_ALU : target_e'(r[29:28]);
    ins.rs1           = $random(seed);
    ins.rs2           = $random(seed);
    ins.imm           = $random(seed);
    ins.pc4           = $random(seed);
    ins.brj_pc        = $random(seed);
    if (r[31:30] == 2'b00) begin
      ins.rs2 = {27'd0, ins.rs2[4:0]};   // Small divisors and shift amounts
      ins.imm = {27'd0, ins.imm[4:0]};
    end
  endtask

  // Wait for busy to fall while the stage registers hold
  task automatic wait_not_busy(output int cycles);
    int n;
    n = 0;
    while (alu_busy && !abort) begin
      @(posedge clk);
      #5;
      check_outputs(exp_req, exp_wb);
      n++;
      if (n >= 100 && alu_busy) begin
        $display("Timeout: alu_busy_o stayed high for 100 cycles at %0t", $time);
        timeouts++;
        abort = 1'b1;
      end
    end
    cycles = n;
  endtask

  task automatic finish_instr(input exe_in_t ins, input bit check_latency);
    mem_req_t want_req;
    wb_t      want_wb;
    int       cycles;
    wait_not_busy(cycles);
    if (!abort) begin
      if (check_latency && ins.alu_op[4]) begin
        check_val("alu_busy_o cycles", cycles, MD_STEPS + 1);   // Start cycle plus one per step
      end
      check_val("alu_o", alu_out, model_result(ins));   // Unregistered result valid once idle
      @(posedge clk);
      #5;
      predict(ins, want_req, want_wb);
      check_outputs(want_req, want_wb);
      exp_req = want_req;
      exp_wb  = want_wb;
    end
  endtask

  task automatic run_instr(input exe_in_t ins);
    e_in = ins;
    #1;
    check_val("alu_busy_o", 32'(alu_busy), 32'(ins.alu_op[4]));   // High from the start cycle
    finish_instr(ins, 1'b1);
  endtask

  // Present the instruction under stall for hold cycles and release
  task automatic run_stalled(input exe_in_t ins, input int hold);
    bit idle_seen;
    e_in            = ins;
    stall_general_i = 1'b1;
    #1;
    idle_seen = !alu_busy;
    for (int k = 0; k < hold; k++) begin
      @(posedge clk);
      #5;
      check_outputs(exp_req, exp_wb);
      if (alu_busy && idle_seen) begin
        $display("Multiply/divide restarted for a held instruction at %0t", $time);
        errors++;
      end
      if (!alu_busy) idle_seen = 1'b1;
    end
    stall_general_i = 1'b0;
    #1;
    finish_instr(ins, 1'b0);
  endtask

  initial begin
    exe_in_t     ins;
    logic [31:0] r;
    int          hold;
    seed            = 85140;
    checks          = 0;
    errors          = 0;
    timeouts        = 0;
    abort           = 1'b0;
    clk             = 1'b0;
    rst_n           = 1'b0;
    stall_general_i = 1'b0;
    e_in            = '0;
    exp_req         = '0;
    exp_wb          = '0;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // Strobes and busy inactive out of reset
    check_val("m_wb_o.reg_wr", 32'(m_wb.reg_wr), 32'd0);
    check_val("m_req_o.data_rd", 32'(m_req.data_rd), 32'd0);
    check_val("m_req_o.data_wr", 32'(m_req.data_wr), 32'd0);
    check_val("m_req_o.is_load_store", 32'(m_req.is_load_store), 32'd0);
    check_val("alu_busy_o", 32'(alu_busy), 32'd0);

    for (int i = 0; i < 200 && !abort; i++) begin   // RV32I with the ALU target
      rand_instr(1'b0, 1'b1, ins);
      run_instr(ins);
    end
    for (int i = 0; i < 150 && !abort; i++) begin   // Store formatting and targets
      rand_instr(1'b0, 1'b0, ins);
      run_instr(ins);
    end
    for (int i = 0; i < 40 && !abort; i++) begin
      rand_instr(1'b1, 1'b0, ins);
      run_instr(ins);
    end
    for (int i = 0; i < 8 && !abort; i++) begin     // Divide by zero
      rand_instr(1'b1, 1'b0, ins);
      ins.alu_op[2] = 1'b1;
      ins.rs2       = 32'd0;
      ins.imm       = 32'd0;
      run_instr(ins);
    end
    for (int i = 0; i < 4 && !abort; i++) begin     // Most negative over minus one for DIV and REM
      rand_instr(1'b1, 1'b0, ins);
      ins.alu_op[2] = 1'b1;
      ins.alu_op[0] = 1'b0;
      ins.rs1       = 32'h8000_0000;
      ins.rs2       = 32'hffff_ffff;
      ins.imm       = 32'hffff_ffff;
      run_instr(ins);
    end
    for (int i = 0; i < 30 && !abort; i++) begin
      r    = $random(seed);
      hold = 1 + ($unsigned($random(seed)) % 60);   // Often outlasts a muldiv run
      rand_instr(r[0], 1'b0, ins);
      run_stalled(ins, hold);
    end

    $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
exe_pkg.sv
alu.sv
muldiv.sv
exe_ctrl.sv
wb_select.sv
stage_reg.sv
exe_stage.sv
tb_exe_stage.sv

// File: Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_exe_stage \
	  -f filelist.f -o sim_exe

run: build
	./obj_dir/sim_exe > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module exe_stage \
	  -f filelist.f

clean:
	rm -rf obj_dir $(LOG)
